/* rtl/beats_pkg.sv */
// Beat credit shared definitions
package beats_pkg;

        // ------------------------------------------------------------------
        // Virtual FIFO geometry
        // ------------------------------------------------------------------
        localparam int fifo_depth = 64;                     // Beats tracked
        localparam int addr_width = $clog2(fifo_depth);     // Index bits, 6

        // Pointers and count carry one extra bit so full differs from empty

        // ------------------------------------------------------------------
        // Flag thresholds
        // ------------------------------------------------------------------
        localparam int almost_wr_margin = 4;    // Almost full at depth minus this
        localparam int almost_rd_margin = 4;    // Almost empty at or below this

        // Burst length and drain size width
        localparam int size_width = 8;

        // ------------------------------------------------------------------
        // Burst scheduler states
        // ------------------------------------------------------------------
        typedef enum logic [1:0] {
                sched_idle   = 2'd0,    // Waiting for enough beats
                sched_issue  = 2'd1,    // Drain strobe and burst pulse
                sched_settle = 2'd2     // Let the count catch up
        } sched_state_e;

endpackage : beats_pkg

/* rtl/fifo_control.sv */
// Occupancy count and status flags
`timescale 1ns/1ps

module fifo_control import beats_pkg::*; (
        input  logic                  axi_aclk,
        input  logic                  rst_n,
        input  logic [addr_width:0]   wr_ptr_next,    // Write pointer after this edge
        input  logic [addr_width:0]   rd_ptr_next,    // Read pointer after this edge
        output logic [addr_width:0]   count,          // Registered occupancy
        output logic                  full,
        output logic                  almost_full,
        output logic                  empty,
        output logic                  almost_empty
);

        // ------------------------------------------------------------------
        // Next-state occupancy
        // ------------------------------------------------------------------
        logic [addr_width:0] count_next;
        logic                full_next;
        logic                almost_full_next;
        logic                empty_next;
        logic                almost_empty_next;

        // Extra MSB makes the plain difference correct across wrap
        assign count_next = wr_ptr_next - rd_ptr_next;

        // Thresholds from package margins
        assign full_next         = (count_next == (addr_width + 1)'(fifo_depth));
        assign almost_full_next  = (count_next >=
                                    (addr_width + 1)'(fifo_depth - almost_wr_margin));
        assign empty_next        = (count_next == '0);
        assign almost_empty_next = (count_next <= (addr_width + 1)'(almost_rd_margin));

        // ------------------------------------------------------------------
        // Registered outputs
        // ------------------------------------------------------------------
        always_ff @(posedge axi_aclk) begin
                if (!rst_n) begin
                        count        <= '0;
                        full         <= 1'b0;
                        almost_full  <= 1'b0;
                        empty        <= 1'b1;     // Nothing written yet
                        almost_empty <= 1'b1;
                end else begin
                        count        <= count_next;
                        full         <= full_next;
                        almost_full  <= almost_full_next;
                        empty        <= empty_next;
                        almost_empty <= almost_empty_next;
                end
        end

endmodule : fifo_control

/* rtl/drain_ctrl_beats.sv */
// Virtual FIFO drain controller
`timescale 1ns/1ps

module drain_ctrl_beats import beats_pkg::*; (
        input  logic                    axi_aclk,
        input  logic                    rst_n,

        // Beat side
        input  logic                    wr_valid,           // One strobe per beat
        output logic                    wr_ready,           // Not full

        // Drain side
        input  logic                    rd_valid,           // Reserve a burst
        input  logic [size_width-1:0]   rd_size,            // Beats to reserve
        output logic                    rd_ready,           // Not empty

        // Status
        output logic [addr_width:0]     data_available,     // Registered count
        output logic                    wr_full,
        output logic                    wr_almost_full,
        output logic                    rd_empty,
        output logic                    rd_almost_empty
);

        // ------------------------------------------------------------------
        // Pointers
        // ------------------------------------------------------------------
        logic [addr_width:0] wr_ptr;
        logic [addr_width:0] rd_ptr;
        logic [addr_width:0] wr_ptr_next;
        logic [addr_width:0] rd_ptr_next;
        logic                wr_accept;
        logic                rd_accept;

        assign wr_accept = wr_valid && wr_ready;        // Dropped while full
        assign rd_accept = rd_valid && rd_ready;        // Ignored while empty

        // Single beat step on the write side
        assign wr_ptr_next = wr_accept ? wr_ptr + 1'b1 : wr_ptr;

        // Variable step on the drain side
        assign rd_ptr_next = rd_accept ? rd_ptr + (addr_width + 1)'(rd_size) : rd_ptr;

        always_ff @(posedge axi_aclk) begin
                if (!rst_n) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                end else begin
                        wr_ptr <= wr_ptr_next;
                        rd_ptr <= rd_ptr_next;
                end
        end

        // ------------------------------------------------------------------
        // Count and flags
        // ------------------------------------------------------------------
        // Fed with next-state pointers so a beat and a drain on one edge
        // both show up right after that edge
        fifo_control u_fifo_control (
                .axi_aclk     (axi_aclk),
                .rst_n        (rst_n),
                .wr_ptr_next  (wr_ptr_next),
                .rd_ptr_next  (rd_ptr_next),
                .count        (data_available),
                .full         (wr_full),
                .almost_full  (wr_almost_full),
                .empty        (rd_empty),
                .almost_empty (rd_almost_empty)
        );

        // Handshake levels
        assign wr_ready = !wr_full;
        assign rd_ready = !rd_empty;    // Gates drain acceptance

endmodule : drain_ctrl_beats

/* rtl/burst_scheduler.sv */
// Write burst scheduler
`timescale 1ns/1ps

module burst_scheduler import beats_pkg::*; (
        input  logic                    axi_aclk,
        input  logic                    rst_n,
        input  logic                    enable,             // Normal bursts allowed
        input  logic                    flush,              // Drain the tail
        input  logic [size_width-1:0]   burst_len,          // Programmed length
        input  logic [addr_width:0]     data_available,     // Beats on hand

        // Reservation toward the virtual FIFO
        output logic                    drain_valid,
        output logic [size_width-1:0]   drain_size,

        // Announcement toward the engine
        output logic                    burst_start,
        output logic [size_width-1:0]   burst_size
);

        // ------------------------------------------------------------------
        // Launch decision
        // ------------------------------------------------------------------
        sched_state_e          state;
        sched_state_e          state_next;
        logic [size_width-1:0] avail_ext;       // Count in size width
        logic [size_width-1:0] size_pick;
        logic [size_width-1:0] size_q;          // Reserved length
        logic                  normal_go;
        logic                  flush_go;
        logic                  launch;

        assign avail_ext = size_width'(data_available);

        assign normal_go = enable && (avail_ext >= burst_len);   // Full burst ready
        assign flush_go  = flush && (data_available != '0);      // Any residue

        // Count capped at burst_len
        // Equals burst_len whenever normal_go holds
        assign size_pick = (avail_ext < burst_len) ? avail_ext : burst_len;

        assign launch = (state == sched_idle) && (normal_go || flush_go);

        // ------------------------------------------------------------------
        // State machine
        // ------------------------------------------------------------------
        always_comb begin
                state_next = state;
                unique case (state)
                        sched_idle: begin
                                if (normal_go || flush_go) begin
                                        state_next = sched_issue;
                                end
                        end
                        sched_issue:  state_next = sched_settle;    // Single cycle
                        sched_settle: state_next = sched_idle;      // Count updates here
                        default:      state_next = sched_idle;
                endcase
        end

        always_ff @(posedge axi_aclk) begin
                if (!rst_n) begin
                        state <= sched_idle;
                end else begin
                        state <= state_next;
                end
        end

        // Size captured on the launch edge
        always_ff @(posedge axi_aclk) begin
                if (launch) begin
                        size_q <= size_pick;
                end
        end

        // ------------------------------------------------------------------
        // Outputs
        // ------------------------------------------------------------------
        assign drain_valid = (state == sched_issue);
        assign burst_start = (state == sched_issue);    // Same cycle as drain
        assign drain_size  = size_q;
        assign burst_size  = size_q;

endmodule : burst_scheduler

/* rtl/write_drain_top.sv */
// Write drain beat credit top
`timescale 1ns/1ps

module write_drain_top import beats_pkg::*; (
        input  logic                    axi_aclk,
        input  logic                    rst_n,

        // Beat strobes from the data path
        input  logic                    beat_valid,
        output logic                    beat_ready,

        // Configuration levels
        input  logic                    enable,
        input  logic                    flush,
        input  logic [size_width-1:0]   burst_len,

        // Burst announcement
        output logic                    burst_start,
        output logic [size_width-1:0]   burst_size,

        // Occupancy status
        output logic [addr_width:0]     data_available,
        output logic                    full,
        output logic                    almost_full,
        output logic                    empty,
        output logic                    almost_empty
);

        // ------------------------------------------------------------------
        // Scheduler to FIFO reservation
        // ------------------------------------------------------------------
        logic                  drain_valid;
        logic [size_width-1:0] drain_size;

        drain_ctrl_beats u_drain_ctrl (
                .axi_aclk        (axi_aclk),
                .rst_n           (rst_n),
                .wr_valid        (beat_valid),
                .wr_ready        (beat_ready),
                .rd_valid        (drain_valid),
                .rd_size         (drain_size),
                .rd_ready        (),                 // Scheduler polls the count
                .data_available  (data_available),
                .wr_full         (full),
                .wr_almost_full  (almost_full),
                .rd_empty        (empty),
                .rd_almost_empty (almost_empty)
        );

        burst_scheduler u_scheduler (
                .axi_aclk       (axi_aclk),
                .rst_n          (rst_n),
                .enable         (enable),
                .flush          (flush),
                .burst_len      (burst_len),
                .data_available (data_available),
                .drain_valid    (drain_valid),
                .drain_size     (drain_size),
                .burst_start    (burst_start),
                .burst_size     (burst_size)
        );

endmodule : write_drain_top

/* verification/write_drain_asserts.sv */
// Virtual FIFO occupancy checks
`timescale 1ns/1ps

module write_drain_asserts import beats_pkg::*; (
        input logic                axi_aclk,
        input logic                rst_n,
        input logic                wr_valid,
        input logic                rd_valid,
        input logic                rd_ready,
        input logic [addr_width:0] data_available,
        input logic                wr_full,
        input logic                rd_empty
);

        // ------------------------------------------------------------------
        // Occupancy rules
        // ------------------------------------------------------------------
        count_in_range: assert property (@(posedge axi_aclk) disable iff (!rst_n)
                data_available <= (addr_width + 1)'(fifo_depth))
                else $error("occupancy above FIFO depth");

        full_empty_excl: assert property (@(posedge axi_aclk) disable iff (!rst_n)
                !(wr_full && rd_empty))
                else $error("full and empty high together");    // Never both

        // Drain requests only arrive with beats on hand
        drain_not_empty: assert property (@(posedge axi_aclk) disable iff (!rst_n)
                rd_valid |-> rd_ready)
                else $error("drain requested while empty");

        // Beats strobed while full are dropped
        write_not_full: assert property (@(posedge axi_aclk) disable iff (!rst_n)
                (wr_full && wr_valid && !rd_valid) |=>
                        (data_available == (addr_width + 1)'(fifo_depth)))
                else $error("beat accepted while full");

endmodule : write_drain_asserts

bind drain_ctrl_beats write_drain_asserts u_asserts (
        .axi_aclk       (axi_aclk),
        .rst_n          (rst_n),
        .wr_valid       (wr_valid),
        .rd_valid       (rd_valid),
        .rd_ready       (rd_ready),
        .data_available (data_available),
        .wr_full        (wr_full),
        .rd_empty       (rd_empty)
);

/* verification/tb_write_drain_top.sv */
// Write drain beat credit testbench
`timescale 1ns/1ps

module tb_write_drain_top import beats_pkg::*; ();

        typedef logic [addr_width:0]   count_t;
        typedef logic [size_width-1:0] size_t;

        logic   axi_aclk;
        logic   rst_n;
        logic   beat_valid;
        logic   enable;
        logic   flush;
        size_t  burst_len;
        logic   beat_ready;
        logic   burst_start;
        size_t  burst_size;
        count_t data_available;
        logic   full;
        logic   almost_full;
        logic   empty;
        logic   almost_empty;

        integer seed;                   // $random state
        int     model_cnt      = 0;     // Reference occupancy
        int     total_beats    = 0;     // Accepted beats
        int     total_drained  = 0;     // Sum of burst sizes
        int     burst_count    = 0;
        size_t  expect_size_q  = '0;    // Size the next launch should latch
        logic   launch_ok_q    = 1'b0;  // Idle scheduler saw a launch condition
        logic   prev_start_q   = 1'b0;  // burst_start one cycle back

        write_drain_top dut (
                .axi_aclk       (axi_aclk),
                .rst_n          (rst_n),
                .beat_valid     (beat_valid),
                .beat_ready     (beat_ready),
                .enable         (enable),
                .flush          (flush),
                .burst_len      (burst_len),
                .burst_start    (burst_start),
                .burst_size     (burst_size),
                .data_available (data_available),
                .full           (full),
                .almost_full    (almost_full),
                .empty          (empty),
                .almost_empty   (almost_empty)
        );

        initial begin
                axi_aclk = 1'b0;
                forever #4 axi_aclk = ~axi_aclk;        // 8 ns period
        end

        // ------------------------------------------------------------------
        // Reference model
        // ------------------------------------------------------------------
        // Flags as {full, almost_full, empty, almost_empty}
        function automatic logic [3:0] expected_flags(input int cnt);
                logic [3:0] f;
                f[3] = (cnt == fifo_depth);
                f[2] = (cnt >= fifo_depth - almost_wr_margin);
                f[1] = (cnt == 0);
                f[0] = (cnt <= almost_rd_margin);
                return f;
        endfunction

        // Full length in normal mode, tail capped at burst_len on flush
        function automatic size_t expected_burst_size(input int cnt, input int len,
                                                      input logic en);
                if (en && cnt >= len) begin
                        return size_t'(len);
                end
                return (cnt < len) ? size_t'(cnt) : size_t'(len);
        endfunction

        // ------------------------------------------------------------------
        // Checks and failure exits
        // ------------------------------------------------------------------
        task automatic stop_on_failure();
                $display("SIMULATION FAILED");
                $fatal(1);
        endtask

        task automatic abort_run(input string reason);
                $display("%s", reason);
                stop_on_failure();
        endtask

        task automatic check_count(input string name, input count_t actual, input count_t expected);
                if (actual !== expected) begin
                        $display("ERROR at %0t: %s is %0d, expected %0d", $time, name, actual,
                                 expected);
                        stop_on_failure();
                end
        endtask

        task automatic check_flag(input string name, input logic actual, input logic expected);
                if (actual !== expected) begin
                        $display("ERROR at %0t: %s is %0b, expected %0b", $time, name, actual,
                                 expected);
                        stop_on_failure();
                end
        endtask

        task automatic check_size(input string name, input size_t actual, input size_t expected);
                if (actual !== expected) begin
                        $display("ERROR at %0t: %s is %0d, expected %0d", $time, name, actual,
                                 expected);
                        stop_on_failure();
                end
        endtask

        // Compare at mid cycle, then fold in what the next edge will sample
        always @(negedge axi_aclk) begin : compare
                logic [3:0] flags;
                int         cnt_now;
                int         drained;
                int         accepted;
                if (!rst_n) begin
                        model_cnt    = 0;
                        launch_ok_q  = 1'b0;
                        prev_start_q = 1'b0;
                end else begin
                        cnt_now = model_cnt;
                        flags   = expected_flags(cnt_now);
                        check_count("data_available", data_available, count_t'(cnt_now));
                        check_flag("full", full, flags[3]);
                        check_flag("almost_full", almost_full, flags[2]);
                        check_flag("empty", empty, flags[1]);
                        check_flag("almost_empty", almost_empty, flags[0]);
                        check_flag("beat_ready", beat_ready, !flags[3]);
                        check_flag("burst_start", burst_start, launch_ok_q);
                        drained = 0;
                        if (burst_start) begin
                                check_size("burst_size", burst_size, expect_size_q);
                                drained = int'(expect_size_q);     // Reserved at next edge
                                burst_count++;
                                total_drained += int'(burst_size);
                        end
                        accepted     = (beat_valid && beat_ready) ? 1 : 0;
                        total_beats += accepted;
                        model_cnt    = cnt_now + accepted - drained;
                        // Idle means neither the issue nor the settle cycle
                        launch_ok_q   = !burst_start && !prev_start_q &&
                                        ((enable && cnt_now >= int'(burst_len)) ||
                                         (flush && cnt_now != 0));
                        prev_start_q  = burst_start;
                        expect_size_q = expected_burst_size(cnt_now, int'(burst_len), enable);
                end
        end

        // ------------------------------------------------------------------
        // Stimulus helpers
        // ------------------------------------------------------------------
        task automatic drive_random_beats(input int cycles);
                logic [31:0] rnd;
                repeat (cycles) begin
                        @(posedge axi_aclk);
                        rnd = $random(seed);
                        beat_valid <= rnd[0];
                end
        endtask

        task automatic wait_for_full(input int limit);
                int cycles;
                cycles = 0;
                do begin
                        @(negedge axi_aclk);
                        cycles++;
                        if (cycles > limit) abort_run("timeout waiting for full");
                end while (!full);
        endtask

        // Random beats until the burst counter reaches target
        task automatic wait_for_bursts(input int target, input int limit);
                int          cycles;
                logic [31:0] rnd;
                cycles = 0;
                while (burst_count < target) begin
                        @(posedge axi_aclk);
                        rnd = $random(seed);
                        beat_valid <= rnd[0];
                        cycles++;
                        if (cycles > limit) abort_run("timeout waiting for bursts");
                end
        endtask

        task automatic wait_below_len(input int limit);
                int cycles;
                cycles = 0;
                do begin
                        @(negedge axi_aclk);
                        cycles++;
                        if (cycles > limit) abort_run("timeout waiting for count below burst_len");
                end while (data_available >= count_t'(burst_len));
        endtask

        task automatic wait_for_burst_start(input int limit);
                int cycles;
                cycles = 0;
                do begin
                        @(negedge axi_aclk);
                        cycles++;
                        if (cycles > limit) abort_run("timeout waiting for flush burst");
                end while (!burst_start);
        endtask

        // ------------------------------------------------------------------
        // Test sequence
        // ------------------------------------------------------------------
        initial begin : stimulus
                int lens [3];
                int residual;
                lens       = '{8, 16, 5};
                seed       = 32'hce5c_7adc;
                rst_n      = 1'b0;
                beat_valid = 1'b0;
                enable     = 1'b0;
                flush      = 1'b0;
                burst_len  = size_t'(8);
                repeat (3) @(posedge axi_aclk);
                rst_n <= 1'b1;

                @(negedge axi_aclk);                    // Reset state
                check_flag("empty", empty, 1'b1);
                check_flag("almost_empty", almost_empty, 1'b1);
                check_flag("full", full, 1'b0);
                check_flag("almost_full", almost_full, 1'b0);
                check_flag("beat_ready", beat_ready, 1'b1);
                check_flag("burst_start", burst_start, 1'b0);
                check_count("data_available", data_available, '0);

                drive_random_beats(40);                 // Occupancy, no bursts

                beat_valid <= 1'b1;                     // Fill to back-pressure
                wait_for_full(200);
                repeat (6) @(posedge axi_aclk);         // Strobes while full
                beat_valid <= 1'b0;
                @(negedge axi_aclk);
                check_count("data_available", data_available, count_t'(fifo_depth));
                check_flag("beat_ready", beat_ready, 1'b0);

                foreach (lens[i]) begin                 // Normal bursts
                        @(posedge axi_aclk);
                        enable <= 1'b0;
                        repeat (3) @(posedge axi_aclk);
                        burst_len <= size_t'(lens[i]);  // Changed only while disabled
                        enable    <= 1'b1;
                        wait_for_bursts(burst_count + 3, 400);
                end

                @(posedge axi_aclk);
                beat_valid <= 1'b0;
                wait_below_len(200);                    // Leftover under burst_len
                @(posedge axi_aclk);
                enable    <= 1'b0;
                burst_len <= size_t'(16);
                beat_valid <= 1'b1;
                repeat (3) @(posedge axi_aclk);         // Three more beats
                beat_valid <= 1'b0;
                @(posedge axi_aclk);
                residual = model_cnt;
                flush <= 1'b1;
                wait_for_burst_start(20);
                check_size("burst_size", burst_size, size_t'(residual));
                @(posedge axi_aclk);
                flush <= 1'b0;
                @(negedge axi_aclk);
                check_flag("empty", empty, 1'b1);

                @(negedge axi_aclk);                    // Idle, nothing moves
                check_count("data_available", data_available, '0);
                if (total_beats != total_drained + int'(data_available)) begin
                        abort_run("accepted beats differ from drained beats plus count");
                end else begin
                        $display("SIMULATION PASSED");
                        $finish;
                end
        end

endmodule : tb_write_drain_top

/* write_drain_top.f */
rtl/beats_pkg.sv
rtl/fifo_control.sv
rtl/drain_ctrl_beats.sv
rtl/burst_scheduler.sv
rtl/write_drain_top.sv
verification/write_drain_asserts.sv
verification/tb_write_drain_top.sv

/* Makefile */
TOOL  := verilator
FLAGS := --binary --timing --assert -Wno-fatal
TOP   := tb_write_drain_top
FLIST := write_drain_top.f
BUILD := obj_dir
LOG   := sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
